/* icache_top.f */
rtl/icache_cfg_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_way.sv
rtl/icache_victim.sv
rtl/icache_hit_sel.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# builds the icache testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb \
  -f icache_top.f -o icache_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

/* bench/icache_tb.sv */
// icache testbench
// line memory model with a fixed refill delay and directed fetch tests
// for flush, hits, misses, set invalidation and uncached fetches
module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;

  localparam int MODEL_LINES = 1024;
  localparam int RTRN_DELAY  = 3;
  localparam int WAIT_LIMIT  = 100;
  localparam int TEST_IDX    = 5;

  logic        clk_i;
  logic        rst_ni;
  logic        en_i;
  logic        flush_i;
  fetch_req_t  fetch_req_i;
  fetch_rsp_t  fetch_rsp_o;
  mem_req_t    mem_req_o;
  logic        mem_req_valid_o;
  logic        mem_ack_i;
  logic        mem_rtrn_valid_i;
  mem_rtrn_t   mem_rtrn_i;
  logic        miss_o;
  logic        busy_o;

  // memory model of 1024 lines with 16 bytes each
  line_t       mem_line [MODEL_LINES];
  logic [31:0] lfsr_q;

  // what the last fetch saw
  fetch_word_t rsp_data;
  paddr_t      rsp_addr;
  mem_req_t    req_q;
  logic        req_seen;
  logic        miss_seen;
  int          rsp_lat;

  icache_top dut0 (
    .clk_i, .rst_ni, .en_i, .flush_i,
    .fetch_req_i, .fetch_rsp_o,
    .mem_req_o, .mem_req_valid_o, .mem_ack_i,
    .mem_rtrn_valid_i, .mem_rtrn_i,
    .miss_o, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  // galois lfsr stepped once per bit taken
  function automatic logic next_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (b ? 32'hd000_0001 : 32'h0);
    return b;
  endfunction

  function automatic fetch_word_t model_word(paddr_t a);
    line_t l;
    l = mem_line[a[13:4]];
    return l[a[3:2] * 32 +: 32];
  endfunction

  function automatic paddr_t make_addr(int unsigned tag, int unsigned idx, int unsigned word);
    return paddr_t'((tag << (INDEX_W + OFFSET_W)) | (idx << OFFSET_W) | (word << 2));
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "icache_tb stopped at the first error");
  endtask

  task automatic check_word(input string name, input fetch_word_t exp, input fetch_word_t act);
    if (exp !== act) stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input paddr_t exp, input paddr_t act);
    if (exp !== act) stop_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) stop_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_way(input string name, input way_idx_t exp, input way_idx_t act);
    if (exp !== act) stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // waits for busy_o to reach level
  // the fetch and memory ports stay quiet while the cache flushes
  task automatic wait_busy(input string name, input logic level, input int limit);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (busy_o !== level) begin
      if (!level) begin
        check_bit({name, " ready"}, 1'b0, fetch_rsp_o.ready);
        check_bit({name, " response valid"}, 1'b0, fetch_rsp_o.valid);
        check_bit({name, " mem_req_valid"}, 1'b0, mem_req_valid_o);
        check_bit({name, " miss"}, 1'b0, miss_o);
      end
      cnt++;
      if (cnt > limit) stop_run($sformatf("%s: busy_o never went to %b", name, level));
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  // one fetch while the memory model answers requests on its own
  // outputs are sampled at the falling edge
  // inputs move 1 ns after the rising edge
  task automatic fetch(input string name, input paddr_t addr);
    int  cnt;
    int  rtn_cnt;
    bit  done;
    req_seen  = 1'b0;
    miss_seen = 1'b0;
    rsp_lat   = 0;
    rtn_cnt   = 0;
    cnt       = 0;
    done      = 1'b0;
    fetch_req_i = '{valid: 1'b1, addr: addr};
    @(negedge clk_i);
    while (!fetch_rsp_o.ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) stop_run($sformatf("%s: fetch was never accepted", name));
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    fetch_req_i.valid = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      rsp_lat++;
      if (mem_req_valid_o && mem_ack_i) begin
        if (req_seen) stop_run($sformatf("%s: second memory request for one fetch", name));
        req_seen = 1'b1;
        req_q    = mem_req_o;
        rtn_cnt  = RTRN_DELAY;
        if (req_q.addr[31:14] != '0) stop_run($sformatf("%s: request outside the model", name));
      end
      if (miss_o) miss_seen = 1'b1;
      if (fetch_rsp_o.valid) begin
        done     = 1'b1;
        rsp_data = fetch_rsp_o.data;
        rsp_addr = fetch_rsp_o.addr;
      end else if (rsp_lat > WAIT_LIMIT) begin
        stop_run($sformatf("%s: no fetch response before the timeout", name));
      end
      @(posedge clk_i);
      #1;
      mem_rtrn_valid_i = 1'b0;
      if (rtn_cnt > 0) begin
        rtn_cnt--;
        // the whole line comes back even for a word request
        if (rtn_cnt == 0) begin
          mem_rtrn_i = '{rtype: RTRN_IFILL, data: mem_line[req_q.addr[13:4]], inv_idx: '0};
          mem_rtrn_valid_i = 1'b1;
        end
      end
    end
  endtask

  task automatic expect_fetch(input string name, input paddr_t addr, input logic exp_miss);
    fetch(name, addr);
    check_word(name, model_word(addr), rsp_data);
    check_addr({name, " echo"}, addr, rsp_addr);
    check_bit({name, " request"}, exp_miss, req_seen);
    check_bit({name, " miss_o"}, exp_miss, miss_seen);
    if (exp_miss) begin
      check_addr({name, " line address"}, {addr[31:4], 4'h0}, req_q.addr);
      check_bit({name, " nc"}, 1'b0, req_q.nc);
    end else begin
      check_count({name, " hit latency"}, 1, rsp_lat);
    end
  endtask

  task automatic expect_uncached(input string name, input paddr_t addr);
    fetch(name, addr);
    check_word(name, model_word(addr), rsp_data);
    check_bit({name, " request"}, 1'b1, req_seen);
    check_addr({name, " word address"}, {addr[31:2], 2'b00}, req_q.addr);
    check_bit({name, " nc"}, 1'b1, req_q.nc);
    check_bit({name, " miss_o"}, 1'b0, miss_seen);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic reset_then_first_fetch();
    wait_busy("reset flush", 1'b0, NUM_SETS + 8);
    expect_fetch("first fetch", 32'h0000_1234, 1'b1);
  endtask

  task automatic same_line_hits();
    expect_fetch("same line", 32'h0000_1238, 1'b0);
    expect_fetch("same line word 0", 32'h0000_1230, 1'b0);
  endtask

  // an empty set fills ways 0 to 3 in order
  task automatic fill_one_set();
    for (int t = 1; t <= 4; t++) begin
      expect_fetch($sformatf("fill tag %0d", t), make_addr(t, TEST_IDX, t % 4), 1'b1);
      check_way($sformatf("fill tag %0d way", t), way_idx_t'(t - 1), req_q.way);
    end
    for (int t = 1; t <= 4; t++) begin
      expect_fetch($sformatf("hit tag %0d", t), make_addr(t, TEST_IDX, (t + 1) % 4), 1'b0);
    end
    expect_fetch("fifth tag", make_addr(5, TEST_IDX, 1), 1'b1);
    expect_fetch("fifth tag again", make_addr(5, TEST_IDX, 2), 1'b0);
  endtask

  task automatic invalidate_set();
    mem_rtrn_i = '{rtype: RTRN_INV, data: '0, inv_idx: set_idx_t'(TEST_IDX)};
    mem_rtrn_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    mem_rtrn_valid_i = 1'b0;
    for (int t = 1; t <= 5; t++) begin
      expect_fetch($sformatf("after inv tag %0d", t), make_addr(t, TEST_IDX, 0), 1'b1);
      if (t <= 4) check_way($sformatf("after inv tag %0d way", t), way_idx_t'(t - 1), req_q.way);
    end
  endtask

  task automatic flush_and_refetch();
    expect_fetch("before flush", 32'h0000_1234, 1'b0);
    expect_fetch("before flush set", make_addr(5, TEST_IDX, 0), 1'b0);
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    wait_busy("flush start", 1'b1, 8);
    wait_busy("flush", 1'b0, NUM_SETS + 8);
    expect_fetch("after flush", 32'h0000_1234, 1'b1);
    expect_fetch("after flush set", make_addr(5, TEST_IDX, 0), 1'b1);
  endtask

  task automatic uncached_fetches();
    en_i = 1'b0;
    @(posedge clk_i);
    #1;
    expect_uncached("uncached", 32'h0000_1234);
    expect_uncached("uncached repeat", 32'h0000_1234);
    expect_uncached("uncached other", 32'h0000_2a5c);
  endtask

  initial begin : main
    rst_ni           = 1'b0;
    en_i             = 1'b1;
    flush_i          = 1'b0;
    fetch_req_i      = '0;
    // the model acknowledges every request at once
    mem_ack_i        = 1'b1;
    mem_rtrn_valid_i = 1'b0;
    mem_rtrn_i       = '0;
    lfsr_q           = 32'h86d7;
    for (int i = 0; i < MODEL_LINES; i++) begin
      for (int b = 0; b < LINE_W; b++) begin
        mem_line[i][b] = next_bit();
      end
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    reset_then_first_fetch();
    same_line_hits();
    fill_one_set();
    invalidate_set();
    flush_and_refetch();
    uncached_fetches();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* rtl/icache_top.sv */
// icache top
// controller, four ways, hit select and victim choice
module icache_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       en_i,
  input  logic                       flush_i,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output icache_bus_pkg::fetch_rsp_t fetch_rsp_o,
  output icache_bus_pkg::mem_req_t   mem_req_o,
  output logic                       mem_req_valid_o,
  input  logic                       mem_ack_i,
  input  logic                       mem_rtrn_valid_i,
  input  icache_bus_pkg::mem_rtrn_t  mem_rtrn_i,
  output logic                       miss_o,
  output logic                       busy_o
);
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;

  way_ctrl_t              way_ctrl;
  way_rd_t [NUM_WAYS-1:0] way_rd;
  way_mask_t              way_valid;
  fetch_word_t            hit_data;
  way_idx_t               victim;
  logic                   hit;
  logic                   advance;

  icache_ctrl i_ctrl (
    .clk_i,
    .rst_ni,
    .en_i,
    .flush_i,
    .fetch_req_i,
    .fetch_rsp_o,
    .mem_req_o,
    .mem_req_valid_o,
    .mem_ack_i,
    .mem_rtrn_valid_i,
    .mem_rtrn_i,
    .hit_i      (hit),
    .hit_data_i (hit_data),
    .victim_i   (victim),
    .way_ctrl_o (way_ctrl),
    .advance_o  (advance),
    .miss_o,
    .busy_o
  );

  // every way sees the same bus and picks out its own mask bit
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    icache_way i_way (
      .clk_i,
      .rst_ni,
      .ctrl_i   (way_ctrl),
      .way_id_i (way_idx_t'(w)),
      .rd_o     (way_rd[w])
    );
  end

  // tag and word come from the echoed fetch address
  icache_hit_sel i_hit_sel (
    .rd_i    (way_rd),
    .tag_i   (fetch_rsp_o.addr[PADDR_W-1 -: TAG_W]),
    .word_i  (fetch_rsp_o.addr[2 +: WORD_OFF_W]),
    .hit_o   (hit),
    .valid_o (way_valid),
    .data_o  (hit_data)
  );

  icache_victim i_victim (
    .clk_i,
    .rst_ni,
    .valid_i   (way_valid),
    .advance_i (advance),
    .victim_o  (victim)
  );

endmodule

/* rtl/icache_ctrl.sv */
// icache controller
// flush, lookup, miss and invalidation state machine
// holds the fetch address and drives the shared way bus
module icache_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic                        flush_i,
  input  icache_bus_pkg::fetch_req_t  fetch_req_i,
  output icache_bus_pkg::fetch_rsp_t  fetch_rsp_o,
  output icache_bus_pkg::mem_req_t    mem_req_o,
  output logic                        mem_req_valid_o,
  input  logic                        mem_ack_i,
  input  logic                        mem_rtrn_valid_i,
  input  icache_bus_pkg::mem_rtrn_t   mem_rtrn_i,
  input  logic                        hit_i,
  input  icache_cfg_pkg::fetch_word_t hit_data_i,
  input  icache_cfg_pkg::way_idx_t    victim_i,
  output icache_bus_pkg::way_ctrl_t   way_ctrl_o,
  output logic                        advance_o,
  output logic                        miss_o,
  output logic                        busy_o
);
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;

  ctrl_state_e state_d, state_q;
  set_idx_t    flush_cnt_d, flush_cnt_q;
  logic        cache_en_d, cache_en_q;
  logic        flush_d, flush_q;
  paddr_t      addr_q;
  way_idx_t    victim_q;

  logic        rsp_ready, rsp_valid;
  logic        read_en, fill_we, inv_en, flush_en, flush_done;
  tag_t        addr_tag;
  set_idx_t    addr_idx;
  word_off_t   addr_word;
  fetch_word_t fill_word;
  paddr_t      req_addr;

  //////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////
  assign addr_tag  = addr_q[PADDR_W-1 -: TAG_W];
  assign addr_idx  = addr_q[OFFSET_W +: INDEX_W];
  assign addr_word = addr_q[2 +: WORD_OFF_W];
  // requested word out of the returning line
  assign fill_word = mem_rtrn_i.data[addr_word * WORD_W +: WORD_W];

  // line address when cached and word address when uncached
  assign req_addr = cache_en_q ? {addr_q[PADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                               : {addr_q[PADDR_W-1:2], 2'b00};

  assign inv_en     = mem_rtrn_valid_i && (mem_rtrn_i.rtype == RTRN_INV);
  assign flush_done = (flush_cnt_q == set_idx_t'(NUM_SETS - 1));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_comb begin
    state_d         = state_q;
    cache_en_d      = cache_en_q;
    // flush requests wait here until the next idle
    flush_d         = flush_q | flush_i;
    flush_en        = 1'b0;
    read_en         = 1'b0;
    fill_we         = 1'b0;
    rsp_ready       = 1'b0;
    rsp_valid       = 1'b0;
    mem_req_valid_o = 1'b0;
    miss_o          = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        // disabling is immediate while enabling goes through a flush
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_valid_i) begin
          // a return beat owns the way bus this cycle
          rsp_ready = 1'b1;
          if (fetch_req_i.valid) begin
            read_en = 1'b1;
            state_d = READ;
          end
        end
      end
      // way outputs are valid now
      READ: begin
        if (cache_en_q && hit_i) begin
          rsp_valid = 1'b1;
          state_d   = IDLE;
          // back-to-back lookup unless something needs idle
          if (!mem_rtrn_valid_i && !flush_d && en_i) begin
            rsp_ready = 1'b1;
            if (fetch_req_i.valid) begin
              read_en = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // a miss or an uncached fetch holds the request until acknowledged
          mem_req_valid_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_valid_i && (mem_rtrn_i.rtype == RTRN_IFILL)) begin
          rsp_valid = 1'b1;
          // uncached data is passed on and not kept
          fill_we   = cache_en_q;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  assign flush_cnt_d = flush_done ? '0 : (flush_en ? flush_cnt_q + 1'b1 : flush_cnt_q);

  //////////////////////////////////////////////////
  // way bus
  //////////////////////////////////////////////////
  // flush beats invalidation
  // a lookup never meets either of them
  always_comb begin
    way_ctrl_o.rd_en   = read_en;
    way_ctrl_o.wr_en   = flush_en | inv_en | fill_we;
    way_ctrl_o.wr_mask = '1;
    way_ctrl_o.idx     = fetch_req_i.addr[OFFSET_W +: INDEX_W];
    way_ctrl_o.tag     = addr_tag;
    way_ctrl_o.vld     = 1'b0;
    way_ctrl_o.line    = mem_rtrn_i.data;
    if (flush_en) begin
      way_ctrl_o.idx = flush_cnt_q;
    end else if (inv_en) begin
      way_ctrl_o.idx = mem_rtrn_i.inv_idx;
    end else if (fill_we) begin
      // refill goes to the way chosen at request time
      way_ctrl_o.wr_mask = way_mask_t'(1) << victim_q;
      way_ctrl_o.idx     = addr_idx;
      way_ctrl_o.vld     = 1'b1;
    end
  end

  assign advance_o = fill_we;
  assign busy_o    = (state_q != IDLE);

  assign fetch_rsp_o = '{
    ready: rsp_ready,
    valid: rsp_valid,
    data:  (state_q == READ) ? hit_data_i : fill_word,
    addr:  addr_q
  };

  assign mem_req_o = '{addr: req_addr, nc: !cache_en_q, way: victim_i};

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_cnt_q <= '0;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_cnt_q <= flush_cnt_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_en) begin
      addr_q <= fetch_req_i.addr;
    end
    if (mem_req_valid_o && mem_ack_i) begin
      victim_q <= victim_i;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////
  // outside a flush the counter rests at zero
  // so every flush walks all sets from set 0
  legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != FLUSH) |-> (flush_cnt_q == '0))
    else $error("icache: flush counter running outside a flush");

  // no invalidation may land while a refill is pending,
  // so a refill write never shares a cycle with one
  inv_vs_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == MISS) |-> !inv_en)
    else $error("icache: invalidation during a pending refill");

endmodule

/* rtl/icache_hit_sel.sv */
// icache hit select
// compares every way's tag against the fetch tag and picks
// the addressed word out of the hitting way's line
module icache_hit_sel (
  input  icache_bus_pkg::way_rd_t [icache_cfg_pkg::NUM_WAYS-1:0] rd_i,
  input  icache_cfg_pkg::tag_t                                   tag_i,
  input  icache_cfg_pkg::word_off_t                              word_i,
  output logic                                                   hit_o,
  output icache_cfg_pkg::way_mask_t                              valid_o,
  output icache_cfg_pkg::fetch_word_t                            data_o
);
  import icache_cfg_pkg::*;

  way_mask_t                      hit_vec;
  fetch_word_t [NUM_WAYS-1:0]     way_word;

  //////////////////////////////////////////////////
  // per-way compare and word pick
  //////////////////////////////////////////////////
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign valid_o[w]  = rd_i[w].vld;
    assign hit_vec[w]  = rd_i[w].vld && (rd_i[w].tag == tag_i);
    assign way_word[w] = rd_i[w].line[word_i * WORD_W +: WORD_W];
  end

  // and-or mux, the hit vector is one-hot
  always_comb begin
    data_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      data_o = data_o | ({WORD_W{hit_vec[w]}} & way_word[w]);
    end
  end

  assign hit_o = |hit_vec;

  // a line is only ever allocated once, so two ways
  // holding the same tag in one set means the
  // controller refilled a line that was present
  always_comb begin
    assert final ($onehot0(hit_vec))
      else $error("icache: tag hit in more than one way");
  end

endmodule

/* rtl/icache_victim.sv */
// icache victim choice
// lowest invalid way first, otherwise a pseudo-random way
// from an 8-bit galois lfsr that steps on fills into a full set
module icache_victim (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  icache_cfg_pkg::way_mask_t valid_i,
  input  logic                      advance_i,
  output icache_cfg_pkg::way_idx_t  victim_o
);
  import icache_cfg_pkg::*;

  lfsr_t    lfsr_q;
  lfsr_t    lfsr_d;
  logic     all_valid;
  way_idx_t first_inv;

  assign all_valid = &valid_i;

  // scan down so the lowest invalid way wins
  always_comb begin
    first_inv = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        first_inv = way_idx_t'(w);
      end
    end
  end

  // right-shift galois step
  assign lfsr_d = {1'b0, lfsr_q[LFSR_W-1:1]} ^ (lfsr_q[0] ? LFSR_TAPS : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (advance_i && all_valid) begin
      // only a replacement in a full set consumes a random value
      lfsr_q <= lfsr_d;
    end
  end

  assign victim_o = all_valid ? lfsr_q[WAY_IDX_W-1:0] : first_inv;

endmodule

/* rtl/icache_way.sv */
// icache way
// tag, line and valid storage of one way, registered read port
// writes only when the way's own bit of the write mask is set
module icache_way (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  icache_bus_pkg::way_ctrl_t ctrl_i,
  input  icache_cfg_pkg::way_idx_t  way_id_i,
  output icache_bus_pkg::way_rd_t   rd_o
);
  import icache_cfg_pkg::*;

  tag_t                tag_mem  [NUM_SETS];
  line_t               data_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_q;

  logic  we;
  tag_t  rd_tag_q;
  line_t rd_line_q;
  logic  rd_vld_q;

  // this way is addressed by the mask
  assign we = ctrl_i.wr_en & ctrl_i.wr_mask[way_id_i];

  // valid bits, cleared on reset, by flush and by invalidation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      if (we) begin
        valid_q[ctrl_i.idx] <= ctrl_i.vld;
      end
      if (ctrl_i.rd_en) begin
        rd_vld_q <= valid_q[ctrl_i.idx];
      end
    end
  end

  // tag and line only change on a refill
  always_ff @(posedge clk_i) begin
    if (we && ctrl_i.vld) begin
      tag_mem[ctrl_i.idx]  <= ctrl_i.tag;
      data_mem[ctrl_i.idx] <= ctrl_i.line;
    end
    // read data holds until the next lookup
    if (ctrl_i.rd_en) begin
      rd_tag_q  <= tag_mem[ctrl_i.idx];
      rd_line_q <= data_mem[ctrl_i.idx];
    end
  end

  assign rd_o = '{tag: rd_tag_q, vld: rd_vld_q, line: rd_line_q};

endmodule

/* rtl/icache_bus_pkg.sv */
// instruction cache bus types
// fetch port, refill request, memory return and the internal way bus
package icache_bus_pkg;

  //////////////////////////////////////////////////
  // fetch port
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                   valid;
    icache_cfg_pkg::paddr_t addr;
  } fetch_req_t;

  // valid is a single-cycle strobe, addr echoes the accepted fetch
  typedef struct packed {
    logic                        ready;
    logic                        valid;
    icache_cfg_pkg::fetch_word_t data;
    icache_cfg_pkg::paddr_t      addr;
  } fetch_rsp_t;

  //////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////
  typedef struct packed {
    icache_cfg_pkg::paddr_t   addr;
    logic                     nc;
    icache_cfg_pkg::way_idx_t way;
  } mem_req_t;

  typedef enum logic {
    RTRN_IFILL,
    RTRN_INV
  } rtrn_type_e;

  typedef struct packed {
    rtrn_type_e               rtype;
    icache_cfg_pkg::line_t    data;
    icache_cfg_pkg::set_idx_t inv_idx;
  } mem_rtrn_t;

  //////////////////////////////////////////////////
  // controller to ways
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                      rd_en;
    logic                      wr_en;
    icache_cfg_pkg::way_mask_t wr_mask;
    icache_cfg_pkg::set_idx_t  idx;
    icache_cfg_pkg::tag_t      tag;
    logic                      vld;
    icache_cfg_pkg::line_t     line;
  } way_ctrl_t;

  typedef struct packed {
    icache_cfg_pkg::tag_t  tag;
    logic                  vld;
    icache_cfg_pkg::line_t line;
  } way_rd_t;

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

/* rtl/icache_cfg_pkg.sv */
// instruction cache geometry
// 4 ways, 64 sets, 16-byte lines over a 32-bit physical address
// sizes and the vector types that name them
package icache_cfg_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////
  localparam int unsigned NUM_WAYS   = 4;
  localparam int unsigned NUM_SETS   = 64;
  localparam int unsigned LINE_BYTES = 16;

  // derived widths
  localparam int unsigned PADDR_W    = 32;
  localparam int unsigned WORD_W     = 32;
  localparam int unsigned LINE_W     = LINE_BYTES * 8;
  localparam int unsigned WAY_IDX_W  = $clog2(NUM_WAYS);
  localparam int unsigned INDEX_W    = $clog2(NUM_SETS);
  localparam int unsigned OFFSET_W   = $clog2(LINE_BYTES);
  localparam int unsigned WORD_OFF_W = OFFSET_W - 2;
  localparam int unsigned TAG_W      = PADDR_W - INDEX_W - OFFSET_W;

  // replacement lfsr, x^8 + x^6 + x^5 + x^4 + 1 in right-shift form
  localparam int unsigned LFSR_W     = 8;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 8'hb8;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 8'h01;

  //////////////////////////////////////////////////
  // named vectors
  //////////////////////////////////////////////////
  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    set_idx_t;
  typedef logic [WORD_OFF_W-1:0] word_off_t;
  typedef logic [WAY_IDX_W-1:0]  way_idx_t;
  typedef logic [NUM_WAYS-1:0]   way_mask_t;
  typedef logic [WORD_W-1:0]     fetch_word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [LFSR_W-1:0]     lfsr_t;

endpackage
